/* compile.f */
+incdir+hdl
hdl/lc4_pkg.sv
hdl/lc4_regfile.sv
hdl/lc4_decode.sv
hdl/lc4_execute.sv
hdl/lc4_result.sv
hdl/lc4_pipe_top.sv
verif/lc4_pipe_asserts.sv
verif/lc4_pipe_tb.sv

/* Bender.yml */
package:
  name: lc4_pipe

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/lc4_pkg.sv
      - hdl/lc4_regfile.sv
      - hdl/lc4_decode.sv
      - hdl/lc4_execute.sv
      - hdl/lc4_result.sv
      - hdl/lc4_pipe_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verif/lc4_pipe_asserts.sv
      - verif/lc4_pipe_tb.sv

/* verif/lc4_pipe_tb.sv */
// lc4 pipeline testbench
// runs a fixed program through the pipeline and checks every retired instruction
`default_nettype none

`include "lc4_defs.svh"

module lc4_pipe_tb;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int RESET_CYCLES = 10;
   localparam int LATENCY      = 4;    // fetch to retire

   logic             gwe;
   logic             i_arst_n;
   lc4_pkg::word_t   o_cur_pc;
   lc4_pkg::word_t   i_cur_insn;
   lc4_pkg::word_t   o_dmem_addr;
   lc4_pkg::word_t   i_cur_dmem_data;
   logic             o_dmem_we;
   lc4_pkg::word_t   o_dmem_towrite;
   lc4_pkg::retire_t o_retire;

   lc4_pkg::retire_t rows[$];          // program, one expected record per insn
   lc4_pkg::word_t   dmem[64];
   lc4_pkg::word_t   mem16;            // random word the first far load picks up
   lc4_pkg::nzp_t    nzp_hold;         // code left by the last writer
   int               n_rows;
   int               row_idx;
   int               cycles;
   int               run_edges;        // edges since reset release
   int               limit;
   int               errors;

   lc4_pipe_top u_dut (
      .gwe             (gwe),
      .i_arst_n        (i_arst_n),
      .o_cur_pc        (o_cur_pc),
      .i_cur_insn      (i_cur_insn),
      .o_dmem_addr     (o_dmem_addr),
      .i_cur_dmem_data (i_cur_dmem_data),
      .o_dmem_we       (o_dmem_we),
      .o_dmem_towrite  (o_dmem_towrite),
      .o_retire        (o_retire)
   );

   always #20 gwe = ~gwe;              // 40 ns period

   assign i_cur_dmem_data = dmem[o_dmem_addr[5:0]];   // comb read, 64 words

   function automatic lc4_pkg::word_t enc_rrr(input logic [3:0] op, input logic [2:0] d,
                                               input logic [2:0] s, input logic [2:0] sub,
                                               input logic [2:0] t);
      return {op, d, s, sub, t};
   endfunction

   function automatic lc4_pkg::word_t enc_rri(input logic [3:0] op, input logic [2:0] d,
                                               input logic [2:0] s, input logic [4:0] imm5);
      return {op, d, s, 1'b1, imm5};
   endfunction

   // ldr and str, d is the data register of a store
   function automatic lc4_pkg::word_t enc_mem(input logic [3:0] op, input logic [2:0] d,
                                               input logic [2:0] s, input logic [5:0] imm6);
      return {op, d, s, imm6};
   endfunction

   function automatic lc4_pkg::word_t enc_const(input logic [2:0] d, input logic [8:0] imm9);
      return {`LC4_OP_CONST, d, imm9};
   endfunction

   function automatic lc4_pkg::nzp_t sign_code(input lc4_pkg::word_t v);
      if (v[`LC4_WORD_W-1]) begin
         return 3'b100;
      end
      return (v == '0) ? 3'b010 : 3'b001;
   endfunction

   function automatic lc4_pkg::word_t fetch_insn(input lc4_pkg::word_t pc);
      int slot;
      slot = pc - `LC4_RESET_PC;
      return (slot >= 0 && slot < rows.size()) ? rows[slot].insn : 16'h0000;
   endfunction

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         errors++;
         $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
         $display("test failed");
         $fatal(1, "stopping at the first mismatch");
      end
   endtask

   task automatic push_row(input lc4_pkg::word_t insn, input logic rf_we, input logic [2:0] wsel,
                           input lc4_pkg::word_t wdata, input logic dmem_we,
                           input lc4_pkg::word_t addr, input lc4_pkg::word_t data);
      lc4_pkg::retire_t r;
      r           = '0;
      r.valid     = 1'b1;
      r.pc        = `LC4_RESET_PC + rows.size();   // straight line code
      r.insn      = insn;
      r.rf_we     = rf_we;
      r.wsel      = wsel;
      r.wdata     = wdata;
      r.nzp_we    = rf_we;                         // every writer sets the codes
      if (rf_we) begin
         nzp_hold = sign_code(wdata);
      end
      r.nzp       = nzp_hold;                      // stores and nops show the held code
      r.dmem_we   = dmem_we;
      r.dmem_addr = addr;                          // zero unless ldr or str
      r.dmem_data = data;
      rows.push_back(r);
   endtask

   task automatic add_alu(input lc4_pkg::word_t insn, input logic [2:0] d,
                          input lc4_pkg::word_t v);
      push_row(insn, 1'b1, d, v, 1'b0, '0, '0);
   endtask

   task automatic add_load(input lc4_pkg::word_t insn, input logic [2:0] d,
                           input lc4_pkg::word_t addr, input lc4_pkg::word_t v);
      push_row(insn, 1'b1, d, v, 1'b0, addr, v);
   endtask

   task automatic add_store(input lc4_pkg::word_t insn, input lc4_pkg::word_t addr,
                            input lc4_pkg::word_t v);
      push_row(insn, 1'b0, 3'd0, '0, 1'b1, addr, v);
   endtask

   task automatic add_nop(input lc4_pkg::word_t insn);
      push_row(insn, 1'b0, 3'd0, '0, 1'b0, '0, '0);
   endtask

   task automatic build_program();
      nzp_hold = 3'b000;                   // codes are clear out of reset
      // alu chain, operands come from m, w and the w->d path in turn
      add_alu(enc_const(3'd1, 9'h005), 3'd1, 16'h0005);
      add_alu(enc_const(3'd2, 9'h1fd), 3'd2, 16'hfffd);   // -3
      add_alu(enc_rrr(`LC4_OP_ARITH, 3'd3, 3'd1, `LC4_SUB_ADD, 3'd2), 3'd3, 16'h0002);
      add_alu(enc_rrr(`LC4_OP_ARITH, 3'd4, 3'd3, `LC4_SUB_MUL, 3'd1), 3'd4, 16'h000a);
      add_alu(enc_rrr(`LC4_OP_ARITH, 3'd5, 3'd4, `LC4_SUB_SUB, 3'd2), 3'd5, 16'h000d);
      add_alu(enc_rrr(`LC4_OP_LOGIC, 3'd6, 3'd5, `LC4_SUB_AND, 3'd4), 3'd6, 16'h0008);
      add_alu(enc_rrr(`LC4_OP_LOGIC, 3'd7, 3'd6, `LC4_SUB_OR, 3'd1), 3'd7, 16'h000d);
      add_alu(enc_rrr(`LC4_OP_LOGIC, 3'd3, 3'd7, `LC4_SUB_XOR, 3'd5), 3'd3, 16'h0000);
      add_alu(enc_rrr(`LC4_OP_LOGIC, 3'd4, 3'd3, `LC4_SUB_NOT, 3'd0), 3'd4, 16'hffff);
      add_alu(enc_rri(`LC4_OP_ARITH, 3'd5, 3'd4, 5'h01), 3'd5, 16'h0000);
      add_alu(enc_rri(`LC4_OP_LOGIC, 3'd6, 3'd7, 5'h1e), 3'd6, 16'h000c);   // and #-2
      // memory, base r0 = 0x14
      add_alu(enc_const(3'd0, 9'h014), 3'd0, 16'h0014);
      add_store(enc_mem(`LC4_OP_STR, 3'd6, 3'd0, 6'h03), 16'h0017, 16'h000c);
      add_nop(16'hf0ff);                                  // trap, outside the subset
      add_load(enc_mem(`LC4_OP_LDR, 3'd1, 3'd0, 6'h03), 3'd1, 16'h0017, 16'h000c);
      add_nop(16'h0e01);                                  // br, pc never redirects
      add_alu(enc_rrr(`LC4_OP_ARITH, 3'd2, 3'd1, `LC4_SUB_ADD, 3'd1), 3'd2, 16'h0018);
      add_load(enc_mem(`LC4_OP_LDR, 3'd3, 3'd0, 6'h3c), 3'd3, 16'h0010, mem16);
      add_alu(enc_const(3'd4, 9'h1ff), 3'd4, 16'hffff);
      add_alu(enc_rrr(`LC4_OP_LOGIC, 3'd5, 3'd3, `LC4_SUB_XOR, 3'd4), 3'd5, ~mem16);
      add_nop(enc_rrr(`LC4_OP_ARITH, 3'd5, 3'd0, 3'b011, 3'd0));   // div, dropped
      add_store(enc_mem(`LC4_OP_STR, 3'd5, 3'd0, 6'h3f), 16'h0013, ~mem16);
      add_load(enc_mem(`LC4_OP_LDR, 3'd6, 3'd0, 6'h3f), 3'd6, 16'h0013, ~mem16);
   endtask

   task automatic compare_retire(input lc4_pkg::retire_t got, input lc4_pkg::retire_t exp);
      check_val("o_retire.pc", got.pc, exp.pc);
      check_val("o_retire.insn", got.insn, exp.insn);
      check_val("o_retire.rf_we", got.rf_we, exp.rf_we);
      check_val("o_retire.nzp_we", got.nzp_we, exp.nzp_we);
      check_val("o_retire.nzp", got.nzp, exp.nzp);
      check_val("o_retire.dmem_we", got.dmem_we, exp.dmem_we);
      check_val("o_retire.dmem_addr", got.dmem_addr, exp.dmem_addr);
      check_val("o_retire.dmem_data", got.dmem_data, exp.dmem_data);
      if (exp.rf_we) begin
         check_val("o_retire.wsel", got.wsel, exp.wsel);
         check_val("o_retire.wdata", got.wdata, exp.wdata);
      end
   endtask

   // imem model, new word a little after each edge
   always @(posedge gwe) begin
      #2;
      i_cur_insn = fetch_insn(o_cur_pc);
   end

   always @(negedge gwe) begin
      if (i_arst_n && o_dmem_we) begin
         dmem[o_dmem_addr[5:0]] = o_dmem_towrite;
      end
   end

   // retire records checked mid cycle, where they are stable
   always @(negedge gwe) begin
      if (i_arst_n && row_idx < n_rows) begin
         if (o_retire.valid) begin
            check_val("retire cycle", run_edges, row_idx + LATENCY);
            compare_retire(o_retire, rows[row_idx]);
            row_idx++;
         end else if (row_idx == 0) begin
            check_val("o_dmem_we", o_dmem_we, 1'b0);   // bubbles only so far
         end
      end
   end

   always @(posedge gwe) begin
      cycles++;
      if (i_arst_n) begin
         run_edges++;
      end
      if (cycles >= limit) begin
         $display("Timeout: %0d of %0d instructions retired after %0d cycles",
                  row_idx, n_rows, cycles);
         $display("test failed");
         $fatal(1, "cycle limit reached");
      end
   end

   initial begin
      gwe        = 1'b0;
      i_arst_n   = 1'b0;
      i_cur_insn = '0;
      row_idx    = 0;
      cycles     = 0;
      run_edges  = 0;
      errors     = 0;
      void'($urandom(32'h69fd2069));       // seed once, the data words follow from it
      for (int a = 0; a < 64; a++) begin
         dmem[a] = $urandom();
      end
      mem16 = dmem[16];
      build_program();
      n_rows = rows.size();
      limit  = (n_rows + 10) * 2;
      repeat (RESET_CYCLES) @(posedge gwe);
      #2;
      check_val("o_cur_pc", o_cur_pc, `LC4_RESET_PC);
      check_val("o_retire.valid", o_retire.valid, 1'b0);
      i_arst_n = 1'b1;
      wait (row_idx == n_rows);
      if (errors == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* verif/lc4_pipe_asserts.sv */
// lc4 pipeline assertions
// pc stepping, store address and retire enables, bound to the top level
`default_nettype none

module lc4_pipe_asserts (
   input wire                   gwe,
   input wire                   i_arst_n,
   input wire lc4_pkg::word_t   i_cur_pc,
   input wire                   i_dmem_we,
   input wire lc4_pkg::word_t   i_dmem_addr,
   input wire lc4_pkg::retire_t i_retire
);

   timeunit 1ns;
   timeprecision 1ps;

   // nothing redirects fetch, one step per edge once out of reset
   a_pc_step: assert property (@(posedge gwe) disable iff (!i_arst_n)
      $past(i_arst_n) |-> i_cur_pc == $past(i_cur_pc) + 16'd1)
      else $error("pc did not advance by one");

   a_store_addr_known: assert property (@(posedge gwe) disable iff (!i_arst_n)
      i_dmem_we |-> !$isunknown(i_dmem_addr))
      else $error("store with unknown address");

   // enables of a retired insn must be clean 0 or 1
   a_retire_known: assert property (@(posedge gwe) disable iff (!i_arst_n)
      i_retire.valid |-> !$isunknown({i_retire.rf_we, i_retire.nzp_we}))
      else $error("retired insn with unknown write enables");

endmodule

bind lc4_pipe_top lc4_pipe_asserts u_asserts (
   .gwe         (gwe),
   .i_arst_n    (i_arst_n),
   .i_cur_pc    (o_cur_pc),
   .i_dmem_we   (o_dmem_we),
   .i_dmem_addr (o_dmem_addr),
   .i_retire    (o_retire)
);

`default_nettype wire

/* hdl/lc4_pipe_top.sv */
// lc4 five-stage pipeline top
// fetch/decode, execute and memory/writeback stages with their bypass paths
`default_nettype none

module lc4_pipe_top (
   input  wire                     gwe,              // rising edge clock
   input  wire                     i_arst_n,
   output wire lc4_pkg::word_t     o_cur_pc,         // imem address
   input  wire lc4_pkg::word_t     i_cur_insn,       // imem data, same cycle
   output wire lc4_pkg::word_t     o_dmem_addr,
   input  wire lc4_pkg::word_t     i_cur_dmem_data,  // dmem read data, same cycle
   output wire                     o_dmem_we,
   output wire lc4_pkg::word_t     o_dmem_towrite,
   output wire lc4_pkg::retire_t   o_retire          // one record per cycle out of w
);

   wire lc4_pkg::stage_t d_to_x;
   wire lc4_pkg::stage_t x_to_m;
   wire lc4_pkg::word_t  x_alu;
   wire lc4_pkg::fwd_t   m_fwd;    // m->x
   wire lc4_pkg::fwd_t   w_fwd;    // w->x, w->d and the rf write

   lc4_decode u_decode (
      .gwe        (gwe),
      .i_arst_n   (i_arst_n),
      .i_cur_insn (i_cur_insn),
      .i_w_fwd    (w_fwd),
      .o_cur_pc   (o_cur_pc),
      .o_d_to_x   (d_to_x)
   );

   lc4_execute u_execute (
      .gwe      (gwe),
      .i_arst_n (i_arst_n),
      .i_d_to_x (d_to_x),
      .i_m_fwd  (m_fwd),
      .i_w_fwd  (w_fwd),
      .o_x_to_m (x_to_m),
      .o_x_alu  (x_alu)
   );

   lc4_result u_result (
      .gwe             (gwe),
      .i_arst_n        (i_arst_n),
      .i_x_to_m        (x_to_m),
      .i_x_alu         (x_alu),
      .i_cur_dmem_data (i_cur_dmem_data),
      .o_dmem_addr     (o_dmem_addr),
      .o_dmem_we       (o_dmem_we),
      .o_dmem_towrite  (o_dmem_towrite),
      .o_m_fwd         (m_fwd),
      .o_w_fwd         (w_fwd),
      .o_retire        (o_retire)
   );

endmodule

`default_nettype wire

/* hdl/lc4_result.sv */
// lc4 memory and writeback stages
// dmem port in m, writeback select, nzp register, bypass sources and retire trace
`default_nettype none

`include "lc4_defs.svh"

module lc4_result (
   input  wire                    gwe,
   input  wire                    i_arst_n,
   input  wire lc4_pkg::stage_t   i_x_to_m,
   input  wire lc4_pkg::word_t    i_x_alu,
   input  wire lc4_pkg::word_t    i_cur_dmem_data,   // comb read, same m cycle
   output lc4_pkg::word_t         o_dmem_addr,
   output logic                   o_dmem_we,
   output lc4_pkg::word_t         o_dmem_towrite,
   output lc4_pkg::fwd_t          o_m_fwd,
   output lc4_pkg::fwd_t          o_w_fwd,
   output lc4_pkg::retire_t       o_retire
);

   lc4_pkg::stage_t m_q;
   lc4_pkg::stage_t w_q;
   lc4_pkg::word_t  m_alu;
   lc4_pkg::word_t  w_alu;
   lc4_pkg::word_t  w_load;     // dmem read data
   lc4_pkg::word_t  w_store;    // dmem write data
   lc4_pkg::word_t  w_addr;
   lc4_pkg::word_t  wdata;
   lc4_pkg::nzp_t   nzp_new;
   lc4_pkg::nzp_t   nzp_q;

   always_ff @(posedge gwe or negedge i_arst_n) begin
      if (!i_arst_n) begin
         m_q   <= '0;
         w_q   <= '0;
         nzp_q <= '0;
      end else begin
         m_q <= i_x_to_m;
         w_q <= m_q;
         if (w_q.ctrl.nzp_we) begin
            nzp_q <= nzp_new;
         end
      end
   end

   // m and w data words, in step with m_q and w_q
   always_ff @(posedge gwe) begin
      m_alu   <= i_x_alu;
      w_alu   <= m_alu;
      w_load  <= i_cur_dmem_data;
      w_store <= o_dmem_towrite;
      w_addr  <= o_dmem_addr;
   end

   // m stage memory port
   assign o_dmem_addr    = (m_q.ctrl.is_load || m_q.ctrl.is_store) ? m_alu : '0;
   assign o_dmem_we      = m_q.ctrl.is_store;
   assign o_dmem_towrite = m_q.r2_data;

   // a load has no value in m yet, so it is not offered to x
   assign o_m_fwd = '{we: m_q.ctrl.rf_we && !m_q.ctrl.is_load,
                      sel: m_q.ctrl.rd_sel, data: m_alu};

   assign wdata   = w_q.ctrl.is_load ? w_load : w_alu;
   assign o_w_fwd = '{we: w_q.ctrl.rf_we, sel: w_q.ctrl.rd_sel, data: wdata};

   always_comb begin
      if (wdata[`LC4_WORD_W-1]) begin
         nzp_new = 3'b100;
      end else if (wdata == '0) begin
         nzp_new = 3'b010;
      end else begin
         nzp_new = 3'b001;
      end
   end

   always_comb begin
      o_retire.valid     = (w_q.insn != '0);   // 0000h is a bubble
      o_retire.pc        = w_q.pc;
      o_retire.insn      = w_q.insn;
      o_retire.rf_we     = w_q.ctrl.rf_we;
      o_retire.wsel      = w_q.ctrl.rd_sel;
      o_retire.wdata     = wdata;
      o_retire.nzp_we    = w_q.ctrl.nzp_we;
      o_retire.nzp       = w_q.ctrl.nzp_we ? nzp_new : nzp_q;   // held code otherwise
      o_retire.dmem_we   = w_q.ctrl.is_store;
      o_retire.dmem_addr = w_addr;
      o_retire.dmem_data = w_q.ctrl.is_load  ? w_load  :
                           w_q.ctrl.is_store ? w_store : '0;
   end

endmodule

`default_nettype wire

/* hdl/lc4_execute.sv */
// lc4 execute stage
// x latch, m->x and w->x operand bypass, alu
`default_nettype none

module lc4_execute (
   input  wire                    gwe,
   input  wire                    i_arst_n,
   input  wire lc4_pkg::stage_t   i_d_to_x,
   input  wire lc4_pkg::fwd_t     i_m_fwd,     // alu result one slot ahead
   input  wire lc4_pkg::fwd_t     i_w_fwd,     // writeback two slots ahead
   output lc4_pkg::stage_t        o_x_to_m,
   output lc4_pkg::word_t         o_x_alu
);

   lc4_pkg::stage_t x_q;
   lc4_pkg::word_t  op_a;
   lc4_pkg::word_t  op_b;
   lc4_pkg::word_t  alu_b;

   // newest producer wins, m before w before the registered read
   function automatic lc4_pkg::word_t bypass(
      input logic              re,
      input lc4_pkg::reg_sel_t sel,
      input lc4_pkg::word_t    rf_val,
      input lc4_pkg::fwd_t     m,
      input lc4_pkg::fwd_t     w
   );
      if (re && m.we && m.sel == sel) begin
         return m.data;
      end
      if (re && w.we && w.sel == sel) begin
         return w.data;
      end
      return rf_val;
   endfunction

   always_ff @(posedge gwe or negedge i_arst_n) begin
      if (!i_arst_n) begin
         x_q <= '0;                      // nop, no enables
      end else begin
         x_q <= i_d_to_x;
      end
   end

   assign op_a  = bypass(x_q.ctrl.r1_re, x_q.ctrl.r1_sel, x_q.r1_data, i_m_fwd, i_w_fwd);
   assign op_b  = bypass(x_q.ctrl.r2_re, x_q.ctrl.r2_sel, x_q.r2_data, i_m_fwd, i_w_fwd);
   assign alu_b = x_q.ctrl.use_imm ? x_q.ctrl.imm : op_b;

   // ldr and str come through here as add for base + offset
   always_comb begin
      case (x_q.ctrl.alu_op)
         lc4_pkg::ALU_ADD:      o_x_alu = op_a + alu_b;
         lc4_pkg::ALU_SUB:      o_x_alu = op_a - alu_b;
         lc4_pkg::ALU_MUL:      o_x_alu = op_a * alu_b;   // low 16 bits kept
         lc4_pkg::ALU_AND:      o_x_alu = op_a & alu_b;
         lc4_pkg::ALU_OR:       o_x_alu = op_a | alu_b;
         lc4_pkg::ALU_XOR:      o_x_alu = op_a ^ alu_b;
         lc4_pkg::ALU_NOT:      o_x_alu = ~op_a;
         lc4_pkg::ALU_PASS_IMM: o_x_alu = alu_b;          // const
         default:               o_x_alu = '0;
      endcase
   end

   // operands leave bypassed, so a store carries fresh data into m
   always_comb begin
      o_x_to_m         = x_q;
      o_x_to_m.r1_data = op_a;
      o_x_to_m.r2_data = op_b;
   end

endmodule

`default_nettype wire

/* hdl/lc4_decode.sv */
// lc4 fetch and decode stage
// pc counter, d latch, instruction decoder, register reads with w->d bypass
`default_nettype none

`include "lc4_defs.svh"

module lc4_decode (
   input  wire                    gwe,
   input  wire                    i_arst_n,
   input  wire lc4_pkg::word_t    i_cur_insn,   // imem data for o_cur_pc
   input  wire lc4_pkg::fwd_t     i_w_fwd,      // writeback, also the rf write
   output lc4_pkg::word_t         o_cur_pc,
   output lc4_pkg::stage_t        o_d_to_x
);

   lc4_pkg::word_t f_pc;
   lc4_pkg::word_t d_pc;
   lc4_pkg::word_t d_insn;
   lc4_pkg::ctrl_t d_ctrl;
   lc4_pkg::word_t imm5;
   lc4_pkg::word_t imm6;
   lc4_pkg::word_t imm9;
   lc4_pkg::word_t rf_rs_data;
   lc4_pkg::word_t rf_rt_data;

   // pc only counts up, nothing redirects it
   always_ff @(posedge gwe or negedge i_arst_n) begin
      if (!i_arst_n) begin
         f_pc   <= `LC4_RESET_PC;
         d_pc   <= '0;
         d_insn <= '0;                   // nop in d after reset
      end else begin
         f_pc   <= f_pc + 1'b1;
         d_pc   <= f_pc;
         d_insn <= i_cur_insn;
      end
   end

   assign o_cur_pc = f_pc;

   // sign extended immediates
   assign imm5 = {{(`LC4_WORD_W-5){d_insn[4]}}, d_insn[4:0]};
   assign imm6 = {{(`LC4_WORD_W-6){d_insn[5]}}, d_insn[5:0]};
   assign imm9 = {{(`LC4_WORD_W-9){d_insn[8]}}, d_insn[8:0]};

   always_comb begin
      d_ctrl        = '0;                // anything unlisted retires as a nop
      d_ctrl.rd_sel = d_insn[11:9];
      d_ctrl.r1_sel = d_insn[8:6];
      d_ctrl.r2_sel = d_insn[2:0];
      case (d_insn[15:12])
         `LC4_OP_NOP: d_ctrl = '0;       // br is not taken either
         `LC4_OP_ARITH, `LC4_OP_LOGIC: begin
            d_ctrl.r1_re  = 1'b1;
            d_ctrl.rf_we  = 1'b1;
            d_ctrl.nzp_we = 1'b1;
            if (d_insn[5]) begin          // immediate form, add or and
               d_ctrl.use_imm = 1'b1;
               d_ctrl.imm     = imm5;
               d_ctrl.alu_op  = d_insn[14] ? lc4_pkg::ALU_AND : lc4_pkg::ALU_ADD;
            end else if (d_insn[14]) begin
               d_ctrl.r2_re = (d_insn[5:3] != `LC4_SUB_NOT);
               case (d_insn[5:3])
                  `LC4_SUB_AND: d_ctrl.alu_op = lc4_pkg::ALU_AND;
                  `LC4_SUB_NOT: d_ctrl.alu_op = lc4_pkg::ALU_NOT;
                  `LC4_SUB_OR:  d_ctrl.alu_op = lc4_pkg::ALU_OR;
                  `LC4_SUB_XOR: d_ctrl.alu_op = lc4_pkg::ALU_XOR;
                  default:      d_ctrl = '0;
               endcase
            end else begin
               d_ctrl.r2_re = 1'b1;
               case (d_insn[5:3])
                  `LC4_SUB_ADD: d_ctrl.alu_op = lc4_pkg::ALU_ADD;
                  `LC4_SUB_MUL: d_ctrl.alu_op = lc4_pkg::ALU_MUL;
                  `LC4_SUB_SUB: d_ctrl.alu_op = lc4_pkg::ALU_SUB;
                  default:      d_ctrl = '0;   // div dropped
               endcase
            end
         end
         `LC4_OP_LDR: begin
            d_ctrl.r1_re   = 1'b1;       // base
            d_ctrl.use_imm = 1'b1;
            d_ctrl.imm     = imm6;
            d_ctrl.rf_we   = 1'b1;
            d_ctrl.nzp_we  = 1'b1;
            d_ctrl.is_load = 1'b1;
         end
         `LC4_OP_STR: begin
            d_ctrl.r1_re    = 1'b1;      // base
            d_ctrl.r2_sel   = d_insn[11:9];   // store data sits in the rd field
            d_ctrl.r2_re    = 1'b1;
            d_ctrl.use_imm  = 1'b1;
            d_ctrl.imm      = imm6;
            d_ctrl.is_store = 1'b1;
         end
         `LC4_OP_CONST: begin
            d_ctrl.alu_op  = lc4_pkg::ALU_PASS_IMM;
            d_ctrl.use_imm = 1'b1;
            d_ctrl.imm     = imm9;
            d_ctrl.rf_we   = 1'b1;
            d_ctrl.nzp_we  = 1'b1;
         end
         default: d_ctrl = '0;
      endcase
   end

   lc4_regfile u_regfile (
      .gwe       (gwe),
      .i_arst_n  (i_arst_n),
      .i_rs      (d_ctrl.r1_sel),
      .i_rt      (d_ctrl.r2_sel),
      .i_rd      (i_w_fwd.sel),
      .i_wdata   (i_w_fwd.data),
      .i_rd_we   (i_w_fwd.we),
      .o_rs_data (rf_rs_data),
      .o_rt_data (rf_rt_data)
   );

   always_comb begin
      o_d_to_x.pc      = d_pc;
      o_d_to_x.insn    = d_insn;
      o_d_to_x.ctrl    = d_ctrl;
      // w->d bypass, the write lands only at the end of this cycle
      o_d_to_x.r1_data = (i_w_fwd.we && i_w_fwd.sel == d_ctrl.r1_sel) ? i_w_fwd.data
                                                                       : rf_rs_data;
      o_d_to_x.r2_data = (i_w_fwd.we && i_w_fwd.sel == d_ctrl.r2_sel) ? i_w_fwd.data
                                                                       : rf_rt_data;
   end

endmodule

`default_nettype wire

/* hdl/lc4_regfile.sv */
// lc4 register file
// eight words, two async read ports, one write port on the clock edge
`default_nettype none

`include "lc4_defs.svh"

module lc4_regfile (
   input  wire                      gwe,
   input  wire                      i_arst_n,
   input  wire lc4_pkg::reg_sel_t   i_rs,        // read port a
   input  wire lc4_pkg::reg_sel_t   i_rt,        // read port b
   input  wire lc4_pkg::reg_sel_t   i_rd,        // write index
   input  wire lc4_pkg::word_t      i_wdata,
   input  wire                      i_rd_we,
   output lc4_pkg::word_t           o_rs_data,
   output lc4_pkg::word_t           o_rt_data
);

   lc4_pkg::word_t regs [`LC4_NUM_REGS];

   always_ff @(posedge gwe or negedge i_arst_n) begin
      if (!i_arst_n) begin
         for (int i = 0; i < `LC4_NUM_REGS; i++) begin
            regs[i] <= '0;              // all registers start at zero
         end
      end else if (i_rd_we) begin
         regs[i_rd] <= i_wdata;
      end
   end

   // reads see the old value, decode adds the w->d bypass
   assign o_rs_data = regs[i_rs];
   assign o_rt_data = regs[i_rt];

endmodule

`default_nettype wire

/* hdl/lc4_pkg.sv */
// lc4 pipeline shared types
// word and select vectors, decoded control, stage payloads, bypass and retire records
`default_nettype none

`include "lc4_defs.svh"

package lc4_pkg;

   typedef logic [`LC4_WORD_W-1:0]    word_t;     // data or address word
   typedef logic [`LC4_REG_SEL_W-1:0] reg_sel_t;  // register index
   typedef logic [2:0]                nzp_t;      // {n, z, p}

   // alu operation picked by the decoder
   typedef enum logic [3:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_MUL,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_NOT,
      ALU_PASS_IMM   // const, immediate straight through
   } alu_op_t;

   // decoded control, travels with the instruction
   typedef struct packed {
      alu_op_t  alu_op;
      logic     use_imm;    // operand b is imm, not rt
      word_t    imm;        // already sign extended
      reg_sel_t r1_sel;
      logic     r1_re;
      reg_sel_t r2_sel;
      logic     r2_re;
      reg_sel_t rd_sel;
      logic     rf_we;
      logic     nzp_we;
      logic     is_load;
      logic     is_store;
   } ctrl_t;

   // one pipeline slot
   typedef struct packed {
      word_t pc;
      word_t insn;
      ctrl_t ctrl;
      word_t r1_data;
      word_t r2_data;
   } stage_t;

   // bypass source, m or w
   typedef struct packed {
      logic     we;
      reg_sel_t sel;
      word_t    data;
   } fwd_t;

   // trace of one completed instruction
   typedef struct packed {
      logic     valid;
      word_t    pc;
      word_t    insn;
      logic     rf_we;
      reg_sel_t wsel;
      word_t    wdata;
      logic     nzp_we;
      nzp_t     nzp;
      logic     dmem_we;
      word_t    dmem_addr;
      word_t    dmem_data;
   } retire_t;

endpackage

`default_nettype wire

/* hdl/lc4_defs.svh */
// lc4 pipeline constants
// widths, reset pc, major opcodes and alu sub-opcodes
`ifndef LC4_DEFS_SVH
`define LC4_DEFS_SVH

// datapath geometry, fixed by the isa
`define LC4_WORD_W      16
`define LC4_REG_SEL_W   3
`define LC4_NUM_REGS    8

`define LC4_RESET_PC    16'h8200  // first fetch address after reset

// major opcodes, insn[15:12]
`define LC4_OP_NOP      4'b0000   // nop and br share this code
`define LC4_OP_ARITH    4'b0001
`define LC4_OP_LOGIC    4'b0101
`define LC4_OP_LDR      4'b0110
`define LC4_OP_STR      4'b0111
`define LC4_OP_CONST    4'b1001

// arith sub-opcodes, insn[5:3] with insn[5] clear
`define LC4_SUB_ADD     3'b000
`define LC4_SUB_MUL     3'b001
`define LC4_SUB_SUB     3'b010

// logic sub-opcodes, same field
`define LC4_SUB_AND     3'b000
`define LC4_SUB_NOT     3'b001
`define LC4_SUB_OR      3'b010
`define LC4_SUB_XOR     3'b011

`endif
